// ==== hdl/sha_pkg.sv ====
//////////////////////////////
// shared sha-256 definitions
// word and block sizes, round count,
// round constants k and initial hash values
//////////////////////////////
package sha_pkg;

    // sizes
    localparam int word_w      = 32;
    localparam int block_words = 16;
    localparam int num_rounds  = 64;

    // round counter must reach num_rounds itself
    localparam int round_w     = 7;

    // round constants
    // first 32 bits of the fractional parts of the cube roots of the first 64 primes
    localparam logic [word_w-1:0] k_table [0:num_rounds-1] = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    // initial hash values H0..H7
    localparam logic [word_w-1:0] h_init [0:7] = '{
        32'h6a09e667,
        32'hbb67ae85,
        32'h3c6ef372,
        32'ha54ff53a,
        32'h510e527f,
        32'h9b05688c,
        32'h1f83d9ab,
        32'h5be0cd19
    };

endpackage

// ==== hdl/block_loader.sv ====
`timescale 1ns/1ns
//////////////////////////////
// message block loader
// word counter, busy flag and the
// init/start strobes for the compressor
//////////////////////////////
module block_loader (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       msg_init,
    input  logic                       word_valid,
    input  logic [sha_pkg::word_w-1:0] word_data,
    input  logic                       hash_done,
    output logic                       ready,
    output logic                       sched_load,
    output logic [sha_pkg::word_w-1:0] sched_word,
    output logic                       cm_init,
    output logic                       cm_enable
);

    logic [3:0] word_cnt;
    logic       busy;
    logic       accept;
    logic       last_word;

    assign ready     = !busy;
    assign accept    = word_valid && ready;
    assign last_word = (word_cnt == 4'(sha_pkg::block_words - 1));

    // every accepted word goes straight into the schedule window
    assign sched_load = accept;
    assign sched_word = word_data;

    // new message only between blocks
    assign cm_init   = msg_init && ready && (word_cnt == 4'd0);
    assign cm_enable = accept && last_word;

    // counter wraps back to zero with the 16th word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt <= 4'd0;
        end else if (accept) begin
            word_cnt <= word_cnt + 4'd1;
        end
    end

    // busy from the start strobe until the compressor reports done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (cm_enable) begin
            busy <= 1'b1;
        end else if (hash_done) begin
            busy <= 1'b0;
        end
    end

endmodule

// ==== hdl/msg_schedule.sv ====
`timescale 1ns/1ns
//////////////////////////////
// sha-256 message schedule
// 16-word sliding window, loaded with
// message words, expanded per round
//////////////////////////////
module msg_schedule (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       sched_load,
    input  logic [sha_pkg::word_w-1:0] sched_word,
    input  logic                       round_step,
    output logic [sha_pkg::word_w-1:0] w
);

    localparam int last = sha_pkg::block_words - 1;

    // win[j] holds W[t+j] while round t is computed
    logic [sha_pkg::word_w-1:0] win [0:last];
    logic [sha_pkg::word_w-1:0] sig0;
    logic [sha_pkg::word_w-1:0] sig1;
    logic [sha_pkg::word_w-1:0] w_new;
    logic [sha_pkg::word_w-1:0] x1;
    logic [sha_pkg::word_w-1:0] x14;

    assign x1  = win[1];
    assign x14 = win[14];

    // sigma0 = rotr 7 ^ rotr 18 ^ shr 3
    assign sig0 = {x1[6:0], x1[31:7]} ^ {x1[17:0], x1[31:18]} ^ (x1 >> 3);

    // sigma1 = rotr 17 ^ rotr 19 ^ shr 10
    assign sig1 = {x14[16:0], x14[31:17]} ^ {x14[18:0], x14[31:19]} ^ (x14 >> 10);

    // W[t+16] from W[t], W[t+1], W[t+9], W[t+14]
    assign w_new = sig1 + win[9] + sig0 + win[0];

    // oldest word feeds the current round
    assign w = win[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j <= last; j++) begin
                win[j] <= '0;
            end
        end else if (sched_load || round_step) begin
            for (int j = 0; j < last; j++) begin
                win[j] <= win[j+1];
            end
            // load and step never overlap, the loader is idle while hashing
            win[last] <= sched_load ? sched_word : w_new;
        end
    end

endmodule

// ==== hdl/accel_compressor.sv ====
`timescale 1ns/1ns
//////////////////////////////
// sha-256 round compressor
// round fsm, working registers a to h,
// chaining value and held digest
//////////////////////////////
module accel_compressor (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cm_init,
    input  logic                         cm_enable,
    input  logic [sha_pkg::word_w-1:0]   w,
    output logic                         round_step,
    output logic                         hash_done,
    output logic [8*sha_pkg::word_w-1:0] cm_out
);

    typedef enum logic [2:0] {IDLE, INIT, UPD1, HASH, UPD2, DONE} state_t;

    state_t state;
    state_t next_state;

    logic [sha_pkg::round_w-1:0] rnd;
    logic [sha_pkg::word_w-1:0]  a, b, c, d, e, f, g, h;
    logic [sha_pkg::word_w-1:0]  chain      [0:7];
    logic [sha_pkg::word_w-1:0]  chain_next [0:7];
    logic [sha_pkg::word_w-1:0]  t1, t2;
    logic [sha_pkg::word_w-1:0]  maj_abc, ch_efg, sum0_a, sum1_e;
    logic                        load_init, load_work, add_chain;
    logic                        is_hashing;
    logic                        rounds_done;

    assign rounds_done = (rnd == sha_pkg::round_w'(sha_pkg::num_rounds));
    assign round_step  = is_hashing;

    // round function
    assign maj_abc = (a & b) ^ (b & c) ^ (c & a);
    assign ch_efg  = (e & f) ^ (~e & g);
    // Sigma0 = rotr 2 ^ rotr 13 ^ rotr 22
    assign sum0_a  = {a[1:0], a[31:2]} ^ {a[12:0], a[31:13]} ^ {a[21:0], a[31:22]};
    // Sigma1 = rotr 6 ^ rotr 11 ^ rotr 25
    assign sum1_e  = {e[5:0], e[31:6]} ^ {e[10:0], e[31:11]} ^ {e[24:0], e[31:25]};
    assign t1 = h + sum1_e + ch_efg + sha_pkg::k_table[rnd[sha_pkg::round_w-2:0]] + w;
    assign t2 = sum0_a + maj_abc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        load_init  = 1'b0;
        load_work  = 1'b0;
        add_chain  = 1'b0;
        is_hashing = 1'b0;
        hash_done  = 1'b0;
        case (state)
            IDLE: begin
                if (cm_init) begin
                    next_state = INIT;
                end else if (cm_enable) begin
                    next_state = UPD1;
                end
            end
            // restart the chain from the standard values
            INIT: begin
                load_init = 1'b1;
                if (cm_enable) begin
                    next_state = UPD1;
                end
            end
            UPD1: begin
                load_work  = 1'b1;
                next_state = HASH;
            end
            // one extra cycle here to see the counter reach 64
            HASH: begin
                if (rounds_done) begin
                    next_state = UPD2;
                end else begin
                    is_hashing = 1'b1;
                end
            end
            UPD2: begin
                add_chain  = 1'b1;
                next_state = DONE;
            end
            DONE: begin
                hash_done  = 1'b1;
                next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    // working registers
    always_ff @(posedge clk) begin
        if (load_work) begin
            a <= chain[0];
            b <= chain[1];
            c <= chain[2];
            d <= chain[3];
            e <= chain[4];
            f <= chain[5];
            g <= chain[6];
            h <= chain[7];
        end else if (is_hashing) begin
            a <= t1 + t2;
            b <= a;
            c <= b;
            d <= c;
            e <= d + t1;
            f <= e;
            g <= f;
            h <= g;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rnd <= '0;
        end else if (is_hashing) begin
            rnd <= rnd + 1'b1;
        end else if (state != HASH) begin
            rnd <= '0;
        end
    end

    assign chain_next[0] = chain[0] + a;
    assign chain_next[1] = chain[1] + b;
    assign chain_next[2] = chain[2] + c;
    assign chain_next[3] = chain[3] + d;
    assign chain_next[4] = chain[4] + e;
    assign chain_next[5] = chain[5] + f;
    assign chain_next[6] = chain[6] + g;
    assign chain_next[7] = chain[7] + h;

    // chaining value, and the digest that only moves at UPD2
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j < 8; j++) begin
                chain[j] <= '0;
            end
            cm_out <= '0;
        end else if (load_init) begin
            chain <= sha_pkg::h_init;
        end else if (add_chain) begin
            chain  <= chain_next;
            cm_out <= {chain_next[0], chain_next[1], chain_next[2], chain_next[3],
                       chain_next[4], chain_next[5], chain_next[6], chain_next[7]};
        end
    end

endmodule

// ==== hdl/sha256_accel.sv ====
`timescale 1ns/1ns
//////////////////////////////
// sha-256 accelerator top
// block loader, message schedule
// and round compressor
//////////////////////////////
module sha256_accel (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         msg_init,
    input  logic                         word_valid,
    input  logic [sha_pkg::word_w-1:0]   word_data,
    output logic                         ready,
    output logic [8*sha_pkg::word_w-1:0] digest,
    output logic                         digest_valid
);

    logic                       sched_load;
    logic [sha_pkg::word_w-1:0] sched_word;
    logic                       cm_init;
    logic                       cm_enable;
    logic                       round_step;
    logic [sha_pkg::word_w-1:0] w;
    logic                       hash_done;

    // host side, counts words into blocks
    block_loader u_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .msg_init   (msg_init),
        .word_valid (word_valid),
        .word_data  (word_data),
        .hash_done  (hash_done),
        .ready      (ready),
        .sched_load (sched_load),
        .sched_word (sched_word),
        .cm_init    (cm_init),
        .cm_enable  (cm_enable)
    );

    msg_schedule u_sched (
        .clk        (clk),
        .rst_n      (rst_n),
        .sched_load (sched_load),
        .sched_word (sched_word),
        .round_step (round_step),
        .w          (w)
    );

    // done strobe doubles as the digest valid pulse
    accel_compressor u_comp (
        .clk        (clk),
        .rst_n      (rst_n),
        .cm_init    (cm_init),
        .cm_enable  (cm_enable),
        .w          (w),
        .round_step (round_step),
        .hash_done  (hash_done),
        .cm_out     (digest)
    );

    assign digest_valid = hash_done;

endmodule

// ==== tests/sha_ref_model.svh ====
//////////////////////////////
// software sha-256 reference
// rotate and sigma helpers, initial hash,
// one-block compression from a chaining value
//////////////////////////////
`ifndef SHA_REF_MODEL_SVH
`define SHA_REF_MODEL_SVH

function automatic logic [31:0] rotate_right(input logic [31:0] x, input int n);
    return (x >> n) | (x << (32 - n));
endfunction

function automatic logic [31:0] small_sigma0(input logic [31:0] x);
    return rotate_right(x, 7) ^ rotate_right(x, 18) ^ (x >> 3);
endfunction

function automatic logic [31:0] small_sigma1(input logic [31:0] x);
    return rotate_right(x, 17) ^ rotate_right(x, 19) ^ (x >> 10);
endfunction

function automatic logic [31:0] big_sigma0(input logic [31:0] x);
    return rotate_right(x, 2) ^ rotate_right(x, 13) ^ rotate_right(x, 22);
endfunction

function automatic logic [31:0] big_sigma1(input logic [31:0] x);
    return rotate_right(x, 6) ^ rotate_right(x, 11) ^ rotate_right(x, 25);
endfunction

// H0 lands in the top word
function automatic logic [255:0] initial_hash();
    logic [255:0] hv;
    for (int i = 0; i < 8; i++) begin
        hv[255 - 32*i -: 32] = sha_pkg::h_init[i];
    end
    return hv;
endfunction

// full 64-entry schedule, then the rounds over v[0..7] = a..h
function automatic logic [255:0] compress_block(input logic [255:0] hv, input logic [511:0] blk);
    logic [31:0]  wsch [0:63];
    logic [31:0]  v    [0:7];
    logic [31:0]  tmp1;
    logic [31:0]  tmp2;
    logic [255:0] res;
    for (int t = 0; t < 16; t++) begin
        wsch[t] = blk[511 - 32*t -: 32];
    end
    for (int t = 16; t < 64; t++) begin
        wsch[t] = small_sigma1(wsch[t-2]) + wsch[t-7] + small_sigma0(wsch[t-15]) + wsch[t-16];
    end
    for (int i = 0; i < 8; i++) begin
        v[i] = hv[255 - 32*i -: 32];
    end
    for (int t = 0; t < 64; t++) begin
        tmp1 = v[7] + big_sigma1(v[4]) + ((v[4] & v[5]) ^ (~v[4] & v[6]))
             + sha_pkg::k_table[t] + wsch[t];
        tmp2 = big_sigma0(v[0]) + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
        for (int i = 7; i > 0; i--) begin
            v[i] = v[i-1];
        end
        // v[4] now holds the old d
        v[4] = v[4] + tmp1;
        v[0] = tmp1 + tmp2;
    end
    for (int i = 0; i < 8; i++) begin
        res[255 - 32*i -: 32] = hv[255 - 32*i -: 32] + v[i];
    end
    return res;
endfunction

`endif

// ==== tests/tb_sha256_accel.sv ====
`timescale 1ns/1ns
//////////////////////////////
// testbench for the sha-256 accelerator
// reset, abc digest, latency, chaining,
// busy gating and re-initialization
//////////////////////////////
module tb_sha256_accel;

    `include "sha_ref_model.svh"

    // 6 blocks of under 100 cycles each, plus reset and margin
    localparam int max_cycles = 800;
    localparam logic [511:0] abc_block = {32'h61626380, {14{32'h0}}, 32'h00000018};
    localparam logic [255:0] abc_digest =
        256'hba7816bf8f01cfea414140de5dae2223b00361a396177a9cb410ff61f20015ad;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         msg_init;
    logic         word_valid;
    logic [31:0]  word_data;
    logic         ready;
    logic [255:0] digest;
    logic         digest_valid;

    int           seed = 54880;
    int           errors = 0;
    int           checks = 0;
    int           cycle_cnt = 0;
    int           lat;
    logic [255:0] got;
    logic [255:0] exp_a;
    logic [511:0] blk_a;
    logic [511:0] blk_b;

    sha256_accel dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .msg_init     (msg_init),
        .word_valid   (word_valid),
        .word_data    (word_data),
        .ready        (ready),
        .digest       (digest),
        .digest_valid (digest_valid)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: the run did not end within %0d cycles", max_cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    // done pulse lasts one cycle, ready is back right after it
    assert property (@(posedge clk) disable iff (!rst_n) digest_valid |=> !digest_valid)
        else begin
            $display("ERR pulse_width expected 0 actual 1");
            errors++;
        end
    assert property (@(posedge clk) disable iff (!rst_n) digest_valid |=> ready)
        else begin
            $display("ERR ready_after_done expected 1 actual 0");
            errors++;
        end

    task automatic check_value(input string name, input logic [255:0] exp,
                               input logic [255:0] act);
        checks++;
        assert (act === exp)
        else begin
            $display("ERR %s expected %0h actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic make_random_block(output logic [511:0] blk);
        for (int i = 0; i < 16; i++) begin
            blk[511 - 32*i -: 32] = $random(seed);
        end
    endtask

    // called at a falling edge, returns at the falling edge after the done pulse
    task automatic run_block(input logic [511:0] blk, input bit with_init, input bit noisy,
                             output logic [255:0] result, output int cycles);
        if (with_init) begin
            msg_init = 1'b1;
            @(negedge clk);
            msg_init = 1'b0;
        end
        for (int i = 0; i < 16; i++) begin
            word_valid = 1'b1;
            word_data  = blk[511 - 32*i -: 32];
            @(negedge clk);
        end
        word_valid = 1'b0;
        // cycles counts from the edge that took the last word
        cycles = 1;
        while (!digest_valid) begin
            checks++;
            assert (!ready)
            else begin
                $display("ready went high %0d cycles after the last word, before the digest",
                         cycles);
                errors++;
            end
            // stray words, all of them must be dropped
            if (noisy) begin
                word_valid = 1'($random(seed));
                word_data  = $random(seed);
            end
            @(negedge clk);
            cycles++;
        end
        word_valid = 1'b0;
        result = digest;
        @(negedge clk);
        checks++;
        assert (ready)
        else begin
            $display("ready did not return high after the digest pulse");
            errors++;
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        msg_init   = 1'b0;
        word_valid = 1'b0;
        word_data  = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("reset_ready", 256'd1, ready);
        check_value("reset_valid", 256'd0, digest_valid);
        check_value("reset_digest", 256'd0, digest);

        // standard abc vector and its latency
        run_block(abc_block, 1'b1, 1'b0, got, lat);
        check_value("abc_digest", abc_digest, got);
        check_value("abc_model", compress_block(initial_hash(), abc_block), got);
        check_value("latency", 256'd68, lat);

        // two chained random blocks
        make_random_block(blk_a);
        make_random_block(blk_b);
        exp_a = compress_block(initial_hash(), blk_a);
        run_block(blk_a, 1'b1, 1'b0, got, lat);
        check_value("chain_first", exp_a, got);
        run_block(blk_b, 1'b0, 1'b0, got, lat);
        check_value("chain_second", compress_block(exp_a, blk_b), got);

        // noise while busy, then a clean chained block
        make_random_block(blk_a);
        make_random_block(blk_b);
        exp_a = compress_block(initial_hash(), blk_a);
        run_block(blk_a, 1'b1, 1'b1, got, lat);
        check_value("gate_noisy", exp_a, got);
        run_block(blk_b, 1'b0, 1'b0, got, lat);
        check_value("gate_clean", compress_block(exp_a, blk_b), got);

        // new message restarts from the initial hash
        run_block(abc_block, 1'b1, 1'b0, got, lat);
        check_value("reinit_abc", abc_digest, got);

        repeat (2) @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== sha256_accel.f ====
+incdir+tests
hdl/sha_pkg.sv
hdl/block_loader.sv
hdl/msg_schedule.sv
hdl/accel_compressor.sv
hdl/sha256_accel.sv
tests/tb_sha256_accel.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_sha256_accel \
    -f sha256_accel.f -o sim_tb || exit 1
# pass only when the pass line shows up in the output
./obj_dir/sim_tb | tee /dev/stderr | grep -q "Finished with no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
